//--- rtl/mem_bench_macros.svh
`ifndef MEM_BENCH_MACROS_SVH
`define MEM_BENCH_MACROS_SVH

// number of 128-bit words written and then read back
// any power of two up to 2**24 fits the address mapping
`define MEM_BENCH_NUM_WORDS 64

// word i holds this base plus i
`define MEM_BENCH_DATA_BASE 128'h5a5a_c3c3_0f0f_9669_a5a5_3c3c_f0f0_6996

// controller byte address and data beat widths
`define MEM_BENCH_ADDR_W 28
`define MEM_BENCH_DATA_W 128

// clocks per UART bit are kept small for simulation
// must be at least 2 so the stop bit can overlap the ready cycle
`define MEM_BENCH_UART_DIV 16

`endif

//--- rtl/mem_bench_pkg.sv
`include "mem_bench_macros.svh"

package mem_bench_pkg;

    // controller byte address where word i lives at i * 8
    typedef logic [`MEM_BENCH_ADDR_W-1:0] mem_addr_t;

    // one controller data beat
    typedef logic [`MEM_BENCH_DATA_W-1:0] mem_data_t;

    // controller command code and the two codes this design issues
    typedef logic [2:0] mem_cmd_t;
    localparam mem_cmd_t cmd_write = 3'd0;
    localparam mem_cmd_t cmd_read = 3'd1;

    typedef logic [31:0] word_idx_t;
    typedef logic [63:0] cycle_count_t;
    typedef logic [7:0] uart_byte_t;

    // sequencer states in the order the test walks through them
    typedef enum logic [2:0] {
        idle,
        write,
        report_write,
        read,
        read_wait,
        report_read,
        park,
        error
    } bench_state_t;

endpackage

//--- rtl/uart_tx.sv
`timescale 1ns/1ps

`include "mem_bench_macros.svh"

module uart_tx import mem_bench_pkg::*; (
    input  logic       clk_100,
    input  logic       reset_n,
    input  uart_byte_t tx_data,
    input  logic       tx_valid,
    output logic       tx_ready,
    output logic       tx
);

    localparam int unsigned div_w = $clog2(`MEM_BENCH_UART_DIV);

    logic [div_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    logic [9:0]       frame;
    logic             busy;
    logic             frame_end;

    // the frame is released one clock before the stop bit ends
    // that last stop-bit clock is the idle cycle in which the next byte is taken,
    // so back to back bytes take exactly ten bit times each
    assign frame_end = (bit_cnt == 4'd9) && (baud_cnt == div_w'(`MEM_BENCH_UART_DIV - 2));

    assign tx_ready = ~busy;
    assign tx = frame[0];

    always_ff @(posedge clk_100) begin
        if (!reset_n) begin
            busy <= 1'b0;
            baud_cnt <= '0;
            bit_cnt <= '0;
            frame <= '1;
        end else if (!busy) begin
            if (tx_valid) begin
                // stop bit, data lsb first, start bit
                frame <= {1'b1, tx_data, 1'b0};
                busy <= 1'b1;
                baud_cnt <= '0;
                bit_cnt <= '0;
            end
        end else begin
            if (frame_end) begin
                busy <= 1'b0;
            end
            if (baud_cnt == div_w'(`MEM_BENCH_UART_DIV - 1)) begin
                baud_cnt <= '0;
                bit_cnt <= bit_cnt + 4'd1;
                // shift in ones so the line rests high after the stop bit
                frame <= {1'b1, frame[9:1]};
            end else begin
                baud_cnt <= baud_cnt + div_w'(1);
            end
        end
    end

endmodule

//--- rtl/read_checker.sv
`timescale 1ns/1ps

`include "mem_bench_macros.svh"

module read_checker import mem_bench_pkg::*; (
    input  logic      clk_100,
    input  logic      reset_n,
    input  mem_data_t app_rd_data,
    input  logic      app_rd_data_valid,
    output logic      check_done,
    output logic      check_pass
);

    word_idx_t beat_idx;
    mem_data_t expected;
    logic      last_beat;

    // read data comes back in command order, so the beat index is the word index
    assign expected = `MEM_BENCH_DATA_BASE + mem_data_t'(beat_idx);
    assign last_beat = (beat_idx == word_idx_t'(`MEM_BENCH_NUM_WORDS - 1));

    always_ff @(posedge clk_100) begin
        if (!reset_n) begin
            beat_idx <= '0;
            check_done <= 1'b0;
            check_pass <= 1'b0;
        end else if (app_rd_data_valid && !check_done) begin
            if (app_rd_data != expected) begin
                // first bad word ends the check
                check_done <= 1'b1;
                check_pass <= 1'b0;
            end else if (last_beat) begin
                check_done <= 1'b1;
                check_pass <= 1'b1;
            end else begin
                beat_idx <= beat_idx + word_idx_t'(1);
            end
        end
    end

endmodule

//--- rtl/bench_sequencer.sv
`timescale 1ns/1ps

`include "mem_bench_macros.svh"

module bench_sequencer import mem_bench_pkg::*; (
    input  logic       clk_100,
    input  logic       reset_n,
    input  logic       calib_done,
    output mem_addr_t  app_addr,
    output mem_cmd_t   app_cmd,
    output logic       app_en,
    input  logic       app_rdy,
    output mem_data_t  app_wdf_data,
    output logic       app_wdf_wren,
    input  logic       app_wdf_rdy,
    input  logic       check_done,
    input  logic       check_pass,
    output uart_byte_t tx_data,
    output logic       tx_valid,
    input  logic       tx_ready,
    output logic       led
);

    bench_state_t state;
    word_idx_t    word_counter;
    cycle_count_t write_cycles;
    cycle_count_t read_cycles;
    cycle_count_t report_word;
    logic [2:0]   byte_idx;

    logic cmd_taken;
    logic data_taken;
    logic word_done;
    logic last_word;
    logic byte_taken;
    logic write_finish;
    logic read_finish;

    assign app_addr = {word_counter[`MEM_BENCH_ADDR_W-4:0], 3'b000};
    assign app_wdf_data = `MEM_BENCH_DATA_BASE + mem_data_t'(word_counter);

    assign cmd_taken = app_en & app_rdy;
    assign data_taken = app_wdf_wren & app_wdf_rdy;

    // the enables double as per-port pending flags
    // a port whose enable already dropped has had its part of the current word accepted
    assign word_done = (cmd_taken | ~app_en) & (data_taken | ~app_wdf_wren);
    assign last_word = (word_counter == word_idx_t'(`MEM_BENCH_NUM_WORDS - 1));

    assign write_finish = (state == write) && word_done && last_word;
    assign read_finish = (state == read_wait) && check_done && check_pass;

    assign byte_taken = tx_valid & tx_ready;
    assign tx_data = report_word[7:0];

    // the counters also tick on the finishing edge, so that edge is added here
    always_ff @(posedge clk_100) begin
        if (write_finish) begin
            report_word <= write_cycles + cycle_count_t'(1);
        end else if (read_finish) begin
            report_word <= read_cycles + cycle_count_t'(1);
        end else if (byte_taken) begin
            report_word <= {8'h00, report_word[63:8]};
        end
    end

    always_ff @(posedge clk_100) begin
        if (!reset_n) begin
            state <= idle;
            app_cmd <= cmd_write;
            app_en <= 1'b0;
            app_wdf_wren <= 1'b0;
            word_counter <= '0;
            write_cycles <= '0;
            read_cycles <= '0;
            tx_valid <= 1'b0;
            byte_idx <= '0;
            led <= 1'b0;
        end else begin
            // byte index wraps back to zero after each eight-byte report
            if (byte_taken) begin
                byte_idx <= byte_idx + 3'd1;
            end

            case (state)
                idle: begin
                    if (calib_done) begin
                        app_cmd <= cmd_write;
                        app_en <= 1'b1;
                        app_wdf_wren <= 1'b1;
                        state <= write;
                    end
                end

                write: begin
                    write_cycles <= write_cycles + cycle_count_t'(1);
                    if (word_done) begin
                        if (last_word) begin
                            app_en <= 1'b0;
                            app_wdf_wren <= 1'b0;
                            tx_valid <= 1'b1;
                            state <= report_write;
                        end else begin
                            // both halves of this word are in, so go straight to the next
                            word_counter <= word_counter + word_idx_t'(1);
                            app_en <= 1'b1;
                            app_wdf_wren <= 1'b1;
                        end
                    end else begin
                        if (cmd_taken) begin
                            app_en <= 1'b0;
                        end
                        if (data_taken) begin
                            app_wdf_wren <= 1'b0;
                        end
                    end
                end

                report_write: begin
                    if (byte_taken && byte_idx == 3'd7) begin
                        tx_valid <= 1'b0;
                        word_counter <= '0;
                        app_cmd <= cmd_read;
                        app_en <= 1'b1;
                        state <= read;
                    end
                end

                read: begin
                    read_cycles <= read_cycles + cycle_count_t'(1);
                    if (cmd_taken) begin
                        if (last_word) begin
                            app_en <= 1'b0;
                            state <= read_wait;
                        end else begin
                            word_counter <= word_counter + word_idx_t'(1);
                        end
                    end
                end

                read_wait: begin
                    read_cycles <= read_cycles + cycle_count_t'(1);
                    if (check_done) begin
                        if (check_pass) begin
                            tx_valid <= 1'b1;
                            state <= report_read;
                        end else begin
                            state <= error;
                        end
                    end
                end

                report_read: begin
                    if (byte_taken && byte_idx == 3'd7) begin
                        tx_valid <= 1'b0;
                        state <= park;
                    end
                end

                park: begin
                    led <= 1'b1;
                end

                error: begin
                    // blinking led flags a data mismatch
                    led <= ~led;
                end
            endcase
        end
    end

endmodule

//--- rtl/mem_bench_top.sv
`timescale 1ns/1ps

module mem_bench_top import mem_bench_pkg::*; (
    input  logic      clk_100,
    input  logic      reset_n,
    input  logic      calib_done,

    // controller command port
    output mem_addr_t app_addr,
    output mem_cmd_t  app_cmd,
    output logic      app_en,
    input  logic      app_rdy,

    // controller write-data port
    output mem_data_t app_wdf_data,
    output logic      app_wdf_wren,
    input  logic      app_wdf_rdy,

    // controller read-data port without back-pressure
    input  mem_data_t app_rd_data,
    input  logic      app_rd_data_valid,

    output logic      uart_tx,
    output logic      led
);

    uart_byte_t tx_data;
    logic       tx_valid;
    logic       tx_ready;
    logic       check_done;
    logic       check_pass;

    bench_sequencer u_bench_sequencer (
        .clk_100      (clk_100),
        .reset_n      (reset_n),
        .calib_done   (calib_done),
        .app_addr     (app_addr),
        .app_cmd      (app_cmd),
        .app_en       (app_en),
        .app_rdy      (app_rdy),
        .app_wdf_data (app_wdf_data),
        .app_wdf_wren (app_wdf_wren),
        .app_wdf_rdy  (app_wdf_rdy),
        .check_done   (check_done),
        .check_pass   (check_pass),
        .tx_data      (tx_data),
        .tx_valid     (tx_valid),
        .tx_ready     (tx_ready),
        .led          (led)
    );

    read_checker u_read_checker (
        .clk_100           (clk_100),
        .reset_n           (reset_n),
        .app_rd_data       (app_rd_data),
        .app_rd_data_valid (app_rd_data_valid),
        .check_done        (check_done),
        .check_pass        (check_pass)
    );

    uart_tx u_uart_tx (
        .clk_100  (clk_100),
        .reset_n  (reset_n),
        .tx_data  (tx_data),
        .tx_valid (tx_valid),
        .tx_ready (tx_ready),
        .tx       (uart_tx)
    );

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

`include "mem_bench_macros.svh"

module mem_model import mem_bench_pkg::*; (
    input  logic      clk_100,
    input  logic      reset_n,
    input  logic      corrupt,
    input  mem_addr_t app_addr,
    input  mem_cmd_t  app_cmd,
    input  logic      app_en,
    output logic      app_rdy,
    input  mem_data_t app_wdf_data,
    input  logic      app_wdf_wren,
    output logic      app_wdf_rdy,
    output mem_data_t app_rd_data,
    output logic      app_rd_data_valid,
    output logic      calib_done
);

    logic        rdy_reg = 1'b0;
    logic        wdf_rdy_reg = 1'b0;
    logic        valid_reg = 1'b0;
    logic        calib_reg = 1'b0;
    mem_data_t   rd_data_reg = '0;
    logic [15:0] lfsr = 16'd42;
    int          now;
    int          calib_wait;
    int          bad_word;
    int          bad_bit;
    mem_data_t   store[mem_addr_t];
    mem_addr_t   wr_addr_q[$];
    mem_data_t   wr_data_q[$];
    mem_addr_t   rd_addr_q[$];
    int          rd_due_q[$];

    assign app_rdy = rdy_reg;
    assign app_wdf_rdy = wdf_rdy_reg;
    assign app_rd_data = rd_data_reg;
    assign app_rd_data_valid = valid_reg;
    assign calib_done = calib_reg;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(logic [15:0] state);
        return state[0] ? ((state >> 1) ^ 16'hb400) : (state >> 1);
    endfunction

    task automatic draw_bits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr = lfsr_step(lfsr);
        end
    endtask

    always @(posedge clk_100) begin
        int        r;
        int        due;
        mem_addr_t a;
        mem_data_t d;
        if (!reset_n) begin
            rdy_reg <= 1'b0;
            wdf_rdy_reg <= 1'b0;
            valid_reg <= 1'b0;
            calib_reg <= 1'b0;
            now = 0;
            store.delete();
            wr_addr_q.delete();
            wr_data_q.delete();
            rd_addr_q.delete();
            rd_due_q.delete();
            draw_bits(3, r);
            calib_wait = 4 + r;
            draw_bits(16, r);
            bad_word = r % `MEM_BENCH_NUM_WORDS;
            draw_bits(7, r);
            bad_bit = r;
        end else begin
            now = now + 1;
            if (calib_wait > 0) begin
                calib_wait = calib_wait - 1;
            end else begin
                calib_reg <= 1'b1;
            end
            // each ready drops on about one cycle in four, independently
            draw_bits(2, r);
            rdy_reg <= (r != 0);
            draw_bits(2, r);
            wdf_rdy_reg <= (r != 0);
            if (app_en && app_rdy) begin
                if (app_cmd == cmd_write) begin
                    wr_addr_q.push_back(app_addr);
                end else begin
                    // reads take 2 to 5 cycles and are pushed back where needed to stay in order
                    draw_bits(2, r);
                    due = now + 2 + r;
                    if (rd_due_q.size() > 0 && due <= rd_due_q[$]) begin
                        due = rd_due_q[$] + 1;
                    end
                    rd_addr_q.push_back(app_addr);
                    rd_due_q.push_back(due);
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                wr_data_q.push_back(app_wdf_data);
            end
            // a write lands once both its command and its data have arrived
            if (wr_addr_q.size() > 0 && wr_data_q.size() > 0) begin
                a = wr_addr_q.pop_front();
                d = wr_data_q.pop_front();
                if (corrupt && a == mem_addr_t'(bad_word * 8)) begin
                    d = d ^ (mem_data_t'(1) << bad_bit);
                end
                store[a] = d;
            end
            if (rd_due_q.size() > 0 && rd_due_q[0] <= now) begin
                a = rd_addr_q.pop_front();
                due = rd_due_q.pop_front();
                rd_data_reg <= store[a];
                valid_reg <= 1'b1;
            end else begin
                valid_reg <= 1'b0;
            end
        end
    end

endmodule

//--- tests/tb_mem_bench.sv
`timescale 1ns/1ps

`include "mem_bench_macros.svh"

module tb_mem_bench import mem_bench_pkg::*; ();

    // one run is about 16 uart frames of 160 clocks plus two stalled 64-word phases,
    // under 4000 cycles, so this covers both runs with a wide margin
    localparam int timeout_cycles = 20000;
    localparam int num_words = `MEM_BENCH_NUM_WORDS;

    logic      clk_100 = 1'b0;
    logic      reset_n = 1'b0;
    logic      corrupt = 1'b0;
    logic      calib_done;
    mem_addr_t app_addr;
    mem_cmd_t  app_cmd;
    logic      app_en;
    logic      app_rdy;
    mem_data_t app_wdf_data;
    logic      app_wdf_wren;
    logic      app_wdf_rdy;
    mem_data_t app_rd_data;
    logic      app_rd_data_valid;
    logic      uart_tx;
    logic      led;

    // reference counts are built only from the handshakes seen on the ports
    int           wr_cmds;
    int           wr_beats;
    int           rd_cmds;
    int           rd_beats;
    logic         w_started;
    logic         w_finished;
    logic         r_started;
    logic         r_finished;
    logic         r_last_seen;
    cycle_count_t write_count;
    cycle_count_t read_count;
    logic         rx_busy;
    int           rx_cnt;
    uart_byte_t   rx_shift;
    uart_byte_t   rx_bytes[$];
    int           cycles_run = 0;

    always #50 clk_100 = ~clk_100;

    mem_bench_top u_mem_bench_top (.*);

    mem_model u_mem_model (.*);

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_addr(mem_addr_t actual, mem_addr_t expected, string what);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s expected %h got %h",
                $time, what, expected, actual));
        end
    endtask

    task automatic check_data(mem_data_t actual, mem_data_t expected, string what);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s expected %h got %h",
                $time, what, expected, actual));
        end
    endtask

    task automatic check_count(cycle_count_t actual, cycle_count_t expected, string what);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s expected %0d got %0d",
                $time, what, expected, actual));
        end
    endtask

    task automatic check_byte(uart_byte_t actual, uart_byte_t expected, string what);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s expected %h got %h",
                $time, what, expected, actual));
        end
    endtask

    task automatic check_led(logic actual, logic expected, string what);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch at %0t: %s expected %b got %b",
                $time, what, expected, actual));
        end
    endtask

    always @(posedge clk_100) begin
        cycles_run = cycles_run + 1;
        if (cycles_run > timeout_cycles) begin
            stop_run("timeout: the runs did not finish within the cycle limit");
        end
    end

    // the handshake monitor samples the values that the edge itself acts on
    always @(posedge clk_100) begin
        if (!reset_n) begin
            wr_cmds = 0;
            wr_beats = 0;
            rd_cmds = 0;
            rd_beats = 0;
            w_started = 1'b0;
            w_finished = 1'b0;
            r_started = 1'b0;
            r_finished = 1'b0;
            r_last_seen = 1'b0;
            write_count = '0;
            read_count = '0;
        end else begin
            if (!w_started && app_en && app_cmd == cmd_write) begin
                w_started = 1'b1;
            end
            if (!r_started && app_en && app_cmd == cmd_read) begin
                r_started = 1'b1;
            end
            if (w_started && !w_finished) begin
                write_count = write_count + cycle_count_t'(1);
            end
            // the read phase ends one edge after its last data beat
            if (r_started && !r_finished) begin
                read_count = read_count + cycle_count_t'(1);
                r_finished = r_last_seen;
            end
            if (app_en && app_rdy) begin
                if (app_cmd == cmd_write) begin
                    if (wr_cmds >= num_words) begin
                        stop_run("a write command was accepted after the last word");
                    end
                    check_addr(app_addr, mem_addr_t'(wr_cmds * 8), "write command address");
                    wr_cmds = wr_cmds + 1;
                end else if (app_cmd == cmd_read) begin
                    if (!w_finished || rd_cmds >= num_words) begin
                        stop_run("a read command was accepted outside the read phase");
                    end
                    check_addr(app_addr, mem_addr_t'(rd_cmds * 8), "read command address");
                    rd_cmds = rd_cmds + 1;
                end else begin
                    stop_run("an unknown command code was accepted");
                end
            end
            if (app_wdf_wren && app_wdf_rdy) begin
                if (wr_beats >= num_words) begin
                    stop_run("a write data beat was accepted after the last word");
                end
                check_data(app_wdf_data, `MEM_BENCH_DATA_BASE + mem_data_t'(wr_beats),
                    "write data beat");
                wr_beats = wr_beats + 1;
            end
            if (w_started && wr_cmds == num_words && wr_beats == num_words) begin
                w_finished = 1'b1;
            end
            if (app_rd_data_valid) begin
                rd_beats = rd_beats + 1;
                r_last_seen = (rd_beats == num_words);
            end
        end
    end

    // uart receiver that samples each bit in its middle
    always @(posedge clk_100) begin
        int bit_no;
        if (!reset_n) begin
            rx_busy = 1'b0;
            rx_cnt = 0;
            rx_bytes.delete();
        end else if (!rx_busy) begin
            if (uart_tx == 1'b0) begin
                rx_busy = 1'b1;
                rx_cnt = 0;
            end
        end else begin
            rx_cnt = rx_cnt + 1;
            if (rx_cnt % `MEM_BENCH_UART_DIV == `MEM_BENCH_UART_DIV / 2) begin
                bit_no = rx_cnt / `MEM_BENCH_UART_DIV;
                if (bit_no == 0 && uart_tx !== 1'b0) begin
                    stop_run("the uart start bit did not stay low");
                end else if (bit_no >= 1 && bit_no <= 8) begin
                    rx_shift = {uart_tx, rx_shift[7:1]};
                end else if (bit_no == 9) begin
                    if (uart_tx !== 1'b1) begin
                        stop_run("the uart stop bit is missing");
                    end
                    rx_bytes.push_back(rx_shift);
                    rx_busy = 1'b0;
                end
            end
        end
    end

    task automatic compare_report(input int first, input cycle_count_t count, input string what);
        for (int i = 0; i < 8; i++) begin
            check_byte(rx_bytes[first + i], uart_byte_t'(count >> (8 * i)), what);
        end
    endtask

    task automatic run_bench(input logic with_error);
        logic led_before;
        @(posedge clk_100);
        reset_n <= 1'b0;
        corrupt <= with_error;
        repeat (5) @(posedge clk_100);
        reset_n <= 1'b1;
        @(negedge clk_100);
        while (calib_done !== 1'b1) begin
            if (app_en !== 1'b0 || app_wdf_wren !== 1'b0 || uart_tx !== 1'b1) begin
                stop_run("controller or uart outputs left their idle state before calibration");
            end
            check_led(led, 1'b0, "led before calibration");
            @(negedge clk_100);
        end
        if (!with_error) begin
            while (rx_bytes.size() < 16) @(negedge clk_100);
            check_count(cycle_count_t'(wr_cmds), cycle_count_t'(num_words), "write commands");
            check_count(cycle_count_t'(wr_beats), cycle_count_t'(num_words), "write beats");
            check_count(cycle_count_t'(rd_cmds), cycle_count_t'(num_words), "read commands");
            compare_report(0, write_count, "write cycle report byte");
            compare_report(8, read_count, "read cycle report byte");
            repeat (50) begin
                check_led(led, 1'b1, "led after a passing run");
                @(negedge clk_100);
            end
        end else begin
            while (rx_bytes.size() < 8) @(negedge clk_100);
            compare_report(0, write_count, "write cycle report byte");
            while (led !== 1'b1) @(negedge clk_100);
            // long enough that a ninth byte would have shown up
            repeat (12 * `MEM_BENCH_UART_DIV) begin
                led_before = led;
                @(negedge clk_100);
                check_led(led, ~led_before, "blinking led after a data error");
            end
            check_count(cycle_count_t'(rx_bytes.size()), cycle_count_t'(8), "bytes in error run");
        end
    endtask

    initial begin
        run_bench(1'b0);
        run_bench(1'b1);
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- mem_bench.f
+incdir+rtl
rtl/mem_bench_pkg.sv
rtl/uart_tx.sv
rtl/read_checker.sv
rtl/bench_sequencer.sv
rtl/mem_bench_top.sv
tests/mem_model.sv
tests/tb_mem_bench.sv

//--- Makefile
TOP = tb_mem_bench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module $(TOP) -f mem_bench.f

# the run fails unless the testbench prints its pass line
run: compile
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
